// ==== flist.f ====
rtl/video_gen_pkg.sv
rtl/video_timing.sv
rtl/xr_reg_bank.sv
rtl/line_fetch_fsm.sv
rtl/pixel_shifter.sv
rtl/video_gen.sv
testbench/video_gen_tb.sv

// ==== rtl/line_fetch_fsm.sv ====
//==========================================================================
// reads display words from vram, one every two cycles in the fetch window
//==========================================================================
`timescale 1ns/10ps

module line_fetch_fsm (
    input  logic                   clk,
    input  logic                   reset_i,
    input  video_gen_pkg::hcount_t h_count_i,
    input  logic                   v_visible_i,
    input  logic                   end_of_line_i,
    input  logic                   end_of_frame_i,
    input  logic                   pa_blank_i,
    input  video_gen_pkg::addr_t   pa_start_addr_i,
    input  video_gen_pkg::word_t   pa_line_len_i,
    output logic                   vram_sel_o,
    output video_gen_pkg::addr_t   vram_addr_o,
    input  video_gen_pkg::word_t   vram_data_i,
    output video_gen_pkg::word_t   fetch_word_o,
    output logic                   fetch_valid_o
);
    import video_gen_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;
    addr_t        line_addr;    // first word of current line
    addr_t        word_addr;    // next word to read
    logic         fetch_start;

    assign fetch_start = (h_count_i == hcount_t'(H_MEM_BEGIN)) && v_visible_i && ~pa_blank_i;

    always_comb begin
        state_next = state;
        case (state)
            FETCH_IDLE: begin
                if (fetch_start) begin
                    state_next = FETCH_READ;
                end
            end
            FETCH_READ: state_next = FETCH_LOAD;
            FETCH_LOAD: begin
                // alternate until the window closes
                state_next = (h_count_i == hcount_t'(H_MEM_END)) ? FETCH_IDLE : FETCH_READ;
            end
            default:    state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= FETCH_IDLE;
            line_addr <= '0;
            word_addr <= '0;
        end else begin
            state <= state_next;
            if (end_of_frame_i) begin
                line_addr <= pa_start_addr_i;                   // back to top
            end else if (end_of_line_i && v_visible_i) begin
                line_addr <= line_addr + pa_line_len_i;
            end
            if (state == FETCH_IDLE) begin
                word_addr <= line_addr;
            end else if (state == FETCH_READ) begin
                word_addr <= word_addr + 1'b1;
            end
        end
    end

    assign vram_sel_o    = (state == FETCH_READ);
    assign vram_addr_o   = word_addr;
    assign fetch_valid_o = (state == FETCH_LOAD);
    assign fetch_word_o  = vram_data_i;     // vram answers during LOAD

endmodule

// ==== rtl/pixel_shifter.sv ====
//==========================================================================
// turns fetched words into 8 bpp colour indices with border and blanking
// timing flags are delayed to stay aligned with the colour
//==========================================================================
`timescale 1ns/10ps

module pixel_shifter (
    input  logic                   clk,
    input  logic                   reset_i,
    input  video_gen_pkg::hcount_t h_count_i,
    input  logic                   h_visible_i,
    input  logic                   v_visible_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  video_gen_pkg::word_t   fetch_word_i,
    input  logic                   fetch_valid_i,
    input  video_gen_pkg::color_t  border_color_i,
    input  video_gen_pkg::hcount_t vid_left_i,
    input  video_gen_pkg::hcount_t vid_right_i,
    input  logic                   pa_blank_i,
    input  video_gen_pkg::color_t  pa_colorbase_i,
    output video_gen_pkg::color_t  color_index_o,
    output logic                   dv_de_o,
    output logic                   h_blank_o,
    output logic                   v_blank_o,
    output logic                   hsync_o,
    output logic                   vsync_o
);
    import video_gen_pkg::*;

    hcount_t    pixel_x;
    logic       in_window;
    logic [4:0] flags_in;       // {window, h_vis, v_vis, hsync, vsync}
    logic [4:0] flags_out;
    logic [4:0] flag_pipe [PIXEL_LATENCY-1];
    word_t      shift_word;
    color_t     pixel;

    assign pixel_x   = h_count_i - hcount_t'(OFFSCREEN_WIDTH);
    assign in_window = (pixel_x >= vid_left_i) && (pixel_x < vid_right_i);
    assign flags_in  = {in_window, h_visible_i, v_visible_i, hsync_i, vsync_i};
    assign flags_out = flag_pipe[PIXEL_LATENCY-2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PIXEL_LATENCY - 1; i++) begin
                flag_pipe[i] <= '0;
            end
        end else begin
            flag_pipe[0] <= flags_in;
            for (int i = 1; i < PIXEL_LATENCY - 1; i++) begin
                flag_pipe[i] <= flag_pipe[i - 1];
            end
        end
    end

    // high byte first, then low byte shifted up
    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            shift_word <= fetch_word_i;
        end else begin
            shift_word <= {shift_word[7:0], 8'h00};
        end
    end

    assign pixel = shift_word[15:8] ^ pa_colorbase_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dv_de_o   <= 1'b0;
            h_blank_o <= 1'b1;
            v_blank_o <= 1'b1;
            hsync_o   <= 1'b0;
            vsync_o   <= 1'b0;
        end else begin
            dv_de_o   <= flags_out[3] & flags_out[2];
            h_blank_o <= ~flags_out[3];
            v_blank_o <= ~flags_out[2];
            hsync_o   <= flags_out[1];
            vsync_o   <= flags_out[0];
        end
    end

    always_ff @(posedge clk) begin
        if (flags_out[4] && !pa_blank_i) begin
            color_index_o <= pixel;
        end else begin
            color_index_o <= border_color_i;    // no colour base on border
        end
    end

endmodule

// ==== rtl/video_gen.sv ====
//==========================================================================
// video generator top level, timing, registers, fetch and pixel output
//==========================================================================
`timescale 1ns/10ps

module video_gen (
    input  logic                   clk,
    input  logic                   reset_i,
    // wishbone register port
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [4:0]             wb_adr_i,
    input  video_gen_pkg::word_t   wb_dat_i,
    output video_gen_pkg::word_t   wb_dat_o,
    output logic                   wb_ack_o,
    // vram read port
    output logic                   vram_sel_o,
    output video_gen_pkg::addr_t   vram_addr_o,
    input  video_gen_pkg::word_t   vram_data_i,
    // video out
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   dv_de_o,
    output logic                   h_blank_o,
    output logic                   v_blank_o,
    output video_gen_pkg::color_t  color_index_o,
    output logic                   video_intr_o
);
    import video_gen_pkg::*;

    hcount_t h_count;
    vcount_t v_count;
    logic    h_visible;
    logic    v_visible;
    logic    hsync_raw;     // undelayed sync from the counters
    logic    vsync_raw;
    logic    end_of_line;
    logic    end_of_frame;
    logic    end_of_visible;
    color_t  border_color;
    hcount_t vid_left;
    hcount_t vid_right;
    logic    pa_blank;
    color_t  pa_colorbase;
    addr_t   pa_start_addr;
    word_t   pa_line_len;
    word_t   fetch_word;
    logic    fetch_valid;

    video_timing u_timing (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(h_count), .v_count_o(v_count),
        .h_visible_o(h_visible), .v_visible_o(v_visible),
        .hsync_o(hsync_raw), .vsync_o(vsync_raw),
        .end_of_line_o(end_of_line), .end_of_frame_o(end_of_frame),
        .end_of_visible_o(end_of_visible)
    );

    xr_reg_bank u_regs (
        .clk(clk), .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o),
        .v_count_i(v_count), .end_of_visible_i(end_of_visible),
        .border_color_o(border_color), .vid_left_o(vid_left), .vid_right_o(vid_right),
        .pa_blank_o(pa_blank), .pa_colorbase_o(pa_colorbase),
        .pa_start_addr_o(pa_start_addr), .pa_line_len_o(pa_line_len),
        .video_intr_o(video_intr_o)
    );

    line_fetch_fsm u_fetch (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .v_visible_i(v_visible),
        .end_of_line_i(end_of_line), .end_of_frame_i(end_of_frame),
        .pa_blank_i(pa_blank), .pa_start_addr_i(pa_start_addr),
        .pa_line_len_i(pa_line_len),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .fetch_word_o(fetch_word), .fetch_valid_o(fetch_valid)
    );

    pixel_shifter u_shifter (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .h_visible_i(h_visible), .v_visible_i(v_visible),
        .hsync_i(hsync_raw), .vsync_i(vsync_raw),
        .fetch_word_i(fetch_word), .fetch_valid_i(fetch_valid),
        .border_color_i(border_color), .vid_left_i(vid_left), .vid_right_i(vid_right),
        .pa_blank_i(pa_blank), .pa_colorbase_i(pa_colorbase),
        .color_index_o(color_index_o), .dv_de_o(dv_de_o),
        .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o)
    );

endmodule

// ==== rtl/video_gen_pkg.sv ====
//==========================================================================
// raster constants, register numbers and shared types of the video
// generator; compiled ahead of all other sources
//==========================================================================
package video_gen_pkg;

    // raster geometry, offscreen part leads each line
    localparam int VISIBLE_WIDTH   = 32;
    localparam int VISIBLE_HEIGHT  = 8;
    localparam int OFFSCREEN_WIDTH = 16;        // front porch + sync + back porch
    localparam int TOTAL_WIDTH     = OFFSCREEN_WIDTH + VISIBLE_WIDTH;
    localparam int TOTAL_HEIGHT    = 12;

    localparam int H_SYNC_START    = 4;
    localparam int H_SYNC_END      = 8;         // exclusive
    localparam int V_SYNC_START    = VISIBLE_HEIGHT + 1;
    localparam int V_SYNC_END      = VISIBLE_HEIGHT + 3;

    // first read lands one cycle after H_MEM_BEGIN
    localparam int H_MEM_BEGIN     = OFFSCREEN_WIDTH - 1;
    localparam int H_MEM_END       = TOTAL_WIDTH - 1;   // last load cycle

    localparam int PIXEL_LATENCY   = 3;         // h_count to colour out

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  color_t;
    typedef logic [$clog2(TOTAL_WIDTH)-1:0]  hcount_t;
    typedef logic [$clog2(TOTAL_HEIGHT)-1:0] vcount_t;

    localparam color_t BORDER_RESET = 8'h08;    // dark grey

    typedef enum logic [4:0] {
        XR_VID_CTRL     = 5'h00,
        XR_VID_INTR     = 5'h03,
        XR_VID_LEFT     = 5'h04,
        XR_VID_RIGHT    = 5'h05,
        XR_SCANLINE     = 5'h08,
        XR_VID_HSIZE    = 5'h0A,
        XR_VID_VSIZE    = 5'h0B,
        XR_PA_GFX_CTRL  = 5'h10,
        XR_PA_DISP_ADDR = 5'h12,
        XR_PA_LINE_LEN  = 5'h13
    } xr_reg_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_LOAD
    } fetch_state_e;

endpackage

// ==== rtl/video_timing.sv ====
//==========================================================================
// raster counters with sync, visible flags and end of line/frame strobes
//==========================================================================
`timescale 1ns/10ps

module video_timing (
    input  logic                   clk,
    input  logic                   reset_i,
    output video_gen_pkg::hcount_t h_count_o,
    output video_gen_pkg::vcount_t v_count_o,
    output logic                   h_visible_o,
    output logic                   v_visible_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   end_of_line_o,
    output logic                   end_of_frame_o,
    output logic                   end_of_visible_o
);
    import video_gen_pkg::*;

    logic last_pixel;
    logic last_line;

    assign last_pixel = (h_count_o == hcount_t'(TOTAL_WIDTH - 1));
    assign last_line  = (v_count_o == vcount_t'(TOTAL_HEIGHT - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else if (last_pixel) begin
            h_count_o <= '0;
            v_count_o <= last_line ? '0 : v_count_o + 1'b1;
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end

    // visible area is the right part of the line and the top lines
    assign h_visible_o = (h_count_o >= hcount_t'(OFFSCREEN_WIDTH));
    assign v_visible_o = (v_count_o < vcount_t'(VISIBLE_HEIGHT));

    assign hsync_o = (h_count_o >= hcount_t'(H_SYNC_START)) &&
                     (h_count_o < hcount_t'(H_SYNC_END));
    assign vsync_o = (v_count_o >= vcount_t'(V_SYNC_START)) &&
                     (v_count_o < vcount_t'(V_SYNC_END));

    assign end_of_line_o    = last_pixel;
    assign end_of_frame_o   = last_pixel && last_line;
    assign end_of_visible_o = last_pixel &&
                              (v_count_o == vcount_t'(VISIBLE_HEIGHT - 1));  // last visible line

endmodule

// ==== rtl/xr_reg_bank.sv ====
//==========================================================================
// wishbone classic slave for the video and playfield registers
// one cycle ack, no wait states; also drives the video interrupt pulse
//==========================================================================
`timescale 1ns/10ps

module xr_reg_bank (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [4:0]             wb_adr_i,
    input  video_gen_pkg::word_t   wb_dat_i,
    output video_gen_pkg::word_t   wb_dat_o,
    output logic                   wb_ack_o,
    input  video_gen_pkg::vcount_t v_count_i,
    input  logic                   end_of_visible_i,
    output video_gen_pkg::color_t  border_color_o,
    output video_gen_pkg::hcount_t vid_left_o,
    output video_gen_pkg::hcount_t vid_right_o,
    output logic                   pa_blank_o,
    output video_gen_pkg::color_t  pa_colorbase_o,
    output video_gen_pkg::addr_t   pa_start_addr_o,
    output video_gen_pkg::word_t   pa_line_len_o,
    output logic                   video_intr_o
);
    import video_gen_pkg::*;

    xr_reg_e reg_num;
    logic    req;           // request not yet acked
    logic    wr_en;
    logic    intr_wr;       // forced interrupt, one cycle behind the write
    word_t   rd_data;

    assign reg_num = xr_reg_e'(wb_adr_i);
    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_en   = req & wb_we_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o     <= 1'b0;
            intr_wr      <= 1'b0;
            video_intr_o <= 1'b0;
        end else begin
            wb_ack_o     <= req;
            intr_wr      <= wr_en && (reg_num == XR_VID_INTR);
            video_intr_o <= end_of_visible_i | intr_wr;
        end
    end

    // register writes, visible in the ack cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color_o  <= BORDER_RESET;
            vid_left_o      <= '0;
            vid_right_o     <= hcount_t'(VISIBLE_WIDTH);
            pa_blank_o      <= 1'b1;
            pa_colorbase_o  <= '0;
            pa_start_addr_o <= '0;
            pa_line_len_o   <= word_t'(VISIBLE_WIDTH / 2);  // one word per two pixels
        end else if (wr_en) begin
            case (reg_num)
                XR_VID_CTRL:     border_color_o  <= wb_dat_i[7:0];
                XR_VID_LEFT:     vid_left_o      <= hcount_t'(wb_dat_i);
                XR_VID_RIGHT:    vid_right_o     <= hcount_t'(wb_dat_i);
                XR_PA_GFX_CTRL: begin
                    pa_colorbase_o <= wb_dat_i[15:8];
                    pa_blank_o     <= wb_dat_i[7];
                end
                XR_PA_DISP_ADDR: pa_start_addr_o <= wb_dat_i;
                XR_PA_LINE_LEN:  pa_line_len_o   <= wb_dat_i;
                default: ;      // read-only or unused
            endcase
        end
    end

    always_comb begin
        case (reg_num)
            XR_VID_CTRL:     rd_data = {8'h00, border_color_o};
            XR_VID_LEFT:     rd_data = word_t'(vid_left_o);
            XR_VID_RIGHT:    rd_data = word_t'(vid_right_o);
            XR_SCANLINE:     rd_data = word_t'(v_count_i);
            XR_VID_HSIZE:    rd_data = word_t'(VISIBLE_WIDTH);
            XR_VID_VSIZE:    rd_data = word_t'(VISIBLE_HEIGHT);
            XR_PA_GFX_CTRL:  rd_data = {pa_colorbase_o, pa_blank_o, 7'b0};
            XR_PA_DISP_ADDR: rd_data = pa_start_addr_o;
            XR_PA_LINE_LEN:  rd_data = pa_line_len_o;
            default:         rd_data = '0;
        endcase
    end

    // read data lines up with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

// ==== testbench/video_gen_tb.sv ====
//==========================================================================
// testbench for the video generator: register table over wishbone, vram
// model and a frame monitor that checks sync counts, pixels and interrupts
//==========================================================================
`timescale 1ns/10ps

module video_gen_tb;
    import video_gen_pkg::*;

    localparam int     RUN_FRAMES     = 6;
    localparam int     TIMEOUT_CYCLES = RUN_FRAMES * TOTAL_WIDTH * TOTAL_HEIGHT + 200;
    localparam int     WIN_LEFT       = 4;
    localparam int     WIN_RIGHT      = 28;
    localparam color_t BORDER_COLOR   = 8'h55;

    typedef struct packed {
        logic       we;
        logic [4:0] adr;
        word_t      wdata;
        word_t      exp;
    } reg_step_t;

    logic clk;
    logic reset_i;
    logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [4:0] wb_adr_i;
    word_t wb_dat_i, wb_dat_o, vram_data_i, next_data;
    addr_t vram_addr_o;
    logic vram_sel_o, hsync_o, vsync_o, dv_de_o, h_blank_o, v_blank_o, video_intr_o;
    color_t color_index_o;

    reg_step_t steps[$];
    int     value_errors, other_errors, cycles, checked_frames;
    int     mode, frame_mode;           // 0 off, 1 pixels from vram, 2 blanked
    logic   extra_intr, frame_extra;
    int     x, y, hsync_cnt, vsync_cnt, intr_cnt;
    int     sel_cnt, hvis_cnt, vvis_cnt;
    logic   prev_de, prev_hsync, prev_vsync;
    addr_t  start_addr;
    word_t  line_len, rd;
    color_t colorbase;
    int     seed_val;

    video_gen dut_i (
        .clk(clk), .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
        .color_index_o(color_index_o), .video_intr_o(video_intr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // every address bit feeds both bytes
    function automatic word_t vram_pattern(input addr_t a);
        return {a[7:0] ^ a[15:8], a[15:8] + a[7:0] + 8'h3c};
    endfunction

    // vram answers one cycle after the select
    always begin
        @(posedge clk);
        #2;
        vram_data_i = next_data;
        if (vram_sel_o) begin
            next_data = vram_pattern(vram_addr_o);
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s, got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_color(input string what, input color_t got, input color_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s, got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic add_step(input logic we, input logic [4:0] adr, input word_t wdata,
                            input word_t exp);
        steps.push_back({we, adr, wdata, exp});
    endtask

    // one classic cycle, ack expected in the next cycle and only once
    task automatic wb_access(input logic we, input logic [4:0] adr, input word_t wdata,
                             output word_t rdata);
        int waits;
        waits = 0;
        @(posedge clk);
        #2;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(negedge clk);
        while (!wb_ack_o && waits < 8) begin
            @(negedge clk);
            waits++;
        end
        if (!wb_ack_o) begin
            other_errors++;
            $display("no ack for register %02h", adr);
        end else if (waits != 1) begin
            other_errors++;
            $display("ack for register %02h came after %0d cycles", adr, waits);
        end
        rdata = wb_dat_o;
        @(posedge clk);
        #2;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
        if (wb_ack_o) begin
            other_errors++;
            $display("ack held high a second cycle for register %02h", adr);
        end
    endtask

    function automatic color_t expected_pixel(input int px, input int py, input int m);
        addr_t a;
        word_t w;
        if (m == 2 || px < WIN_LEFT || px >= WIN_RIGHT) begin
            return BORDER_COLOR;
        end
        a = start_addr + addr_t'(py) * line_len + addr_t'(px / 2);
        w = vram_pattern(a);
        return ((px % 2 == 0) ? w[15:8] : w[7:0]) ^ colorbase;
    endfunction

    // frame runs from one vsync fall to the next
    always @(negedge clk) begin
        if (!vsync_o && prev_vsync) begin
            if (frame_mode != 0) begin
                check_word("hsync pulses", word_t'(hsync_cnt), word_t'(TOTAL_HEIGHT));
                check_word("vsync pulses", word_t'(vsync_cnt), 16'd1);
                check_word("visible lines", word_t'(y), word_t'(VISIBLE_HEIGHT));
                check_word("interrupt pulses", word_t'(intr_cnt), word_t'(1 + frame_extra));
                check_word("vram reads", word_t'(sel_cnt),
                           word_t'(frame_mode == 2 ? 0 : VISIBLE_HEIGHT * VISIBLE_WIDTH / 2));
                check_word("h visible cycles", word_t'(hvis_cnt),
                           word_t'(TOTAL_HEIGHT * VISIBLE_WIDTH));
                check_word("v visible cycles", word_t'(vvis_cnt),
                           word_t'(VISIBLE_HEIGHT * TOTAL_WIDTH));
                checked_frames++;
            end
            hsync_cnt   = 0;
            vsync_cnt   = 0;
            intr_cnt    = 0;
            sel_cnt     = 0;
            hvis_cnt    = 0;
            vvis_cnt    = 0;
            y           = 0;
            frame_mode  = mode;
            frame_extra = extra_intr;
        end
        if (hsync_o && !prev_hsync) hsync_cnt++;
        if (vsync_o && !prev_vsync) vsync_cnt++;
        if (video_intr_o) intr_cnt++;
        if (vram_sel_o) sel_cnt++;
        if (!h_blank_o) hvis_cnt++;
        if (!v_blank_o) vvis_cnt++;
        if (dv_de_o) begin
            if (!prev_de) x = 0;
            if (frame_mode != 0) begin
                check_color($sformatf("pixel %0d,%0d", x, y), color_index_o,
                            expected_pixel(x, y, frame_mode));
                check_word($sformatf("blank flags at pixel %0d,%0d", x, y),
                           word_t'({h_blank_o, v_blank_o}), 16'h0);
            end
            x++;
        end else if (prev_de) begin
            if (frame_mode != 0) begin
                check_word($sformatf("width of line %0d", y), word_t'(x),
                           word_t'(VISIBLE_WIDTH));
            end
            y++;
        end
        prev_de    = dv_de_o;
        prev_hsync = hsync_o;
        prev_vsync = vsync_o;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        vram_data_i = '0;
        next_data = '0;
        {value_errors, other_errors, checked_frames, mode, frame_mode} = '0;
        {x, y, hsync_cnt, vsync_cnt, intr_cnt} = '0;
        {sel_cnt, hvis_cnt, vvis_cnt} = '0;
        {extra_intr, frame_extra, prev_de, prev_hsync, prev_vsync} = '0;
        seed_val   = $urandom(32'hef8eab80);
        start_addr = addr_t'($urandom);
        line_len   = word_t'(16 + $urandom % 16);
        colorbase  = color_t'($urandom);

        // reset values first, then writes with readback
        add_step(1'b0, XR_VID_CTRL, 16'h0, {8'h00, BORDER_RESET});
        add_step(1'b0, XR_VID_LEFT, 16'h0, 16'h0);
        add_step(1'b0, XR_VID_RIGHT, 16'h0, word_t'(VISIBLE_WIDTH));
        add_step(1'b0, XR_VID_HSIZE, 16'h0, word_t'(VISIBLE_WIDTH));
        add_step(1'b0, XR_VID_VSIZE, 16'h0, word_t'(VISIBLE_HEIGHT));
        add_step(1'b0, XR_PA_GFX_CTRL, 16'h0, 16'h0080);
        add_step(1'b0, XR_PA_DISP_ADDR, 16'h0, 16'h0);
        add_step(1'b0, XR_PA_LINE_LEN, 16'h0, word_t'(VISIBLE_WIDTH / 2));
        add_step(1'b1, 5'h1f, 16'hbeef, 16'h0);                    // unused number
        add_step(1'b1, XR_VID_HSIZE, 16'h1234, word_t'(VISIBLE_WIDTH));
        add_step(1'b1, XR_VID_CTRL, {8'hff, BORDER_COLOR}, {8'h00, BORDER_COLOR});
        add_step(1'b1, XR_VID_LEFT, word_t'(WIN_LEFT), word_t'(WIN_LEFT));
        add_step(1'b1, XR_VID_RIGHT, word_t'(WIN_RIGHT), word_t'(WIN_RIGHT));
        add_step(1'b1, XR_PA_DISP_ADDR, start_addr, start_addr);
        add_step(1'b1, XR_PA_LINE_LEN, line_len, line_len);
        add_step(1'b1, XR_PA_GFX_CTRL, {colorbase, 8'h7f}, {colorbase, 8'h00});

        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;

        foreach (steps[i]) begin
            if (steps[i].we) begin
                wb_access(1'b1, steps[i].adr, steps[i].wdata, rd);
            end
            wb_access(1'b0, steps[i].adr, 16'h0, rd);
            check_word($sformatf("register %02h", steps[i].adr), rd, steps[i].exp);
        end

        @(negedge vsync_o);
        mode = 1;
        repeat (2) @(negedge vsync_o);
        extra_intr = 1'b1;                              // forced pulse in this frame
        wb_access(1'b1, XR_VID_INTR, 16'h0001, rd);
        @(negedge vsync_o);
        extra_intr = 1'b0;
        mode = 0;
        wb_access(1'b1, XR_PA_GFX_CTRL, {colorbase, 8'h80}, rd);
        wb_access(1'b0, XR_PA_GFX_CTRL, 16'h0, rd);
        check_word("blank readback", rd, {colorbase, 8'h80});
        @(negedge vsync_o);
        mode = 2;
        @(negedge vsync_o);
        mode = 0;
        repeat (4) @(posedge clk);

        // three pixel frames and one blanked frame
        if (checked_frames != 4) begin
            other_errors++;
            $display("frame monitor checked %0d frames instead of 4", checked_frames);
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
